// File: simd_unit.f
+incdir+tests
common/simd_pkg.sv
simd_unit/operand_split.sv
simd_unit/functional_unit.sv
simd_unit/result_merge.sv
simd_unit/simd_unit.sv
tests/tb_simd_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SIMD unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f simd_unit.f \
    --top-module tb_simd_unit \
    --Mdir obj_dir \
    -o tb_simd_unit

./obj_dir/tb_simd_unit > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

// File: tests/simd_model.svh
/*
 * Reference model for the SIMD execution stage, element by element
 */
`ifndef SIMD_MODEL_SVH
`define SIMD_MODEL_SVH

function automatic logic [63:0] width_mask(int ew);
    return (ew >= 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
endfunction

function automatic logic [63:0] elem_get(logic [VLEN-1:0] v, int idx, int ew);
    logic [VLEN-1:0] shifted;
    shifted = v >> (idx * ew);
    return shifted[63:0] & width_mask(ew);
endfunction

// Second operand of element idx, VCNT always compares against rs1
function automatic logic [63:0] operand_b(simd_op_t op, src_sel_t src, logic [63:0] rs1,
                                          logic [IMM_W-1:0] imm, logic [VLEN-1:0] vs1,
                                          int idx, int ew);
    logic [63:0] imm_ext;
    imm_ext = {{(64-IMM_W){imm[IMM_W-1]}}, imm};
    if (op == VCNT || src == SRC_VX) begin
        return rs1 & width_mask(ew);
    end
    if (src == SRC_VI) begin
        return imm_ext & width_mask(ew);
    end
    return elem_get(vs1, idx, ew);
endfunction

function automatic logic [63:0] elem_result(simd_op_t op, logic [63:0] a, logic [63:0] b,
                                            int ew);
    case (op)
        VADD:       return (a + b) & width_mask(ew);
        VSUB:       return (a - b) & width_mask(ew);  // vs2 - vs1
        VAND:       return a & b;
        VOR:        return a | b;
        VXOR:       return a ^ b;
        VSEQ, VCNT: return (a == b) ? 64'd1 : 64'd0;
        default:    return 64'd0;
    endcase
endfunction

function automatic logic [VLEN-1:0] expect_vd(simd_op_t op, sew_t sew, src_sel_t src,
                                              logic [63:0] rs1, logic [IMM_W-1:0] imm,
                                              logic [VLEN-1:0] vs1, logic [VLEN-1:0] vs2,
                                              logic [VLEN-1:0] old_vd, logic [VLEN/8-1:0] vm);
    logic [VLEN-1:0] res;
    logic [63:0]     r;
    int              ew;
    ew  = 8 << int'(sew);
    res = '0;
    for (int e = 0; e < VLEN / ew; e++) begin
        r = vm[e * ew / 8] ? elem_result(op, elem_get(vs2, e, ew),
                                         operand_b(op, src, rs1, imm, vs1, e, ew), ew)
                           : elem_get(old_vd, e, ew);
        res = res | (VLEN'(r) << (e * ew));
    end
    return res;
endfunction

function automatic logic [63:0] expect_rd(simd_op_t op, sew_t sew, logic [63:0] rs1,
                                          logic [VLEN-1:0] vs2);
    int          ew;
    int          ne;
    int unsigned cnt;
    logic        run;
    ew  = 8 << int'(sew);
    ne  = VLEN / ew;
    cnt = 0;
    run = 1'b1;
    case (op)
        VMV_X_S: return elem_get(vs2, 0, ew);
        VEXT:    return (rs1 < 64'(ne)) ? elem_get(vs2, int'(rs1), ew) : 64'd0;
        VCNT: begin
            for (int e = 0; e < ne; e++) begin
                run = run && (elem_get(vs2, e, ew) == (rs1 & width_mask(ew)));
                cnt = run ? cnt + 1 : cnt;
            end
            return 64'(cnt);
        end
        default: return 64'd0;
    endcase
endfunction

`endif

// File: tests/tb_simd_unit.sv
/*
 * Testbench for the SIMD execution unit
 * Random and directed instructions checked against a model after the 2-cycle latency
 */
module tb_simd_unit import simd_pkg::*; ();

    localparam int VLEN           = 256;
    localparam int SEED           = 19738;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_CYCLES     = 400;  // Stimulus cycles including the directed ones
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 50;

    `include "simd_model.svh"

    typedef struct packed {
        int unsigned          due;  // Cycle at which the result must show
        logic                 scalar;
        logic [VLEN-1:0]      vd;
        logic [63:0]          rd;
        logic [TAG_W-1:0]     tag;
    } expect_t;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 valid_i;
    simd_op_t             op_i;
    sew_t                 sew_i;
    src_sel_t             src_sel_i;
    logic [DATA_SIZE-1:0] rs1_data_i;
    logic [IMM_W-1:0]     imm_i;
    logic [VLEN-1:0]      vs1_data_i;
    logic [VLEN-1:0]      vs2_data_i;
    logic [VLEN-1:0]      old_vd_i;
    logic [VLEN/8-1:0]    vm_i;
    logic [TAG_W-1:0]     tag_i;
    logic                 vd_valid_o;
    logic [VLEN-1:0]      vd_data_o;
    logic                 rd_valid_o;
    logic [DATA_SIZE-1:0] rd_data_o;
    logic [TAG_W-1:0]     tag_o;

    expect_t     exp_q[$];
    int unsigned cycle = 0;
    int          stim_count = 0;
    int          checks = 0;
    int          errors = 0;

    simd_unit #(
        .VLEN (VLEN)
    ) simd_unit_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .src_sel_i  (src_sel_i),
        .rs1_data_i (rs1_data_i),
        .imm_i      (imm_i),
        .vs1_data_i (vs1_data_i),
        .vs2_data_i (vs2_data_i),
        .old_vd_i   (old_vd_i),
        .vm_i       (vm_i),
        .tag_i      (tag_i),
        .vd_valid_o (vd_valid_o),
        .vd_data_o  (vd_data_o),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .tag_o      (tag_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [VLEN-1:0] expected,
                               input logic [VLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [VLEN-1:0] rand_vec();
        logic [VLEN-1:0] v;
        for (int i = 0; i < VLEN / 32; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic logic [VLEN/8-1:0] rand_mask();
        logic [VLEN/8-1:0] m;
        for (int i = 0; i < VLEN / 8; i++) begin
            m[i] = 1'($urandom);
        end
        return m;
    endfunction

    function automatic logic [VLEN-1:0] elem_put(logic [VLEN-1:0] v, int idx, int ew,
                                                 logic [63:0] val);
        logic [VLEN-1:0] mask;
        mask = VLEN'(width_mask(ew)) << (idx * ew);
        return (v & ~mask) | (VLEN'(val & width_mask(ew)) << (idx * ew));
    endfunction

    function automatic logic [VLEN-1:0] rep_elem(logic [63:0] val, int ew);
        logic [VLEN-1:0] v;
        v = '0;
        for (int e = 0; e < VLEN / ew; e++) begin
            v = elem_put(v, e, ew, val);
        end
        return v;
    endfunction

    // Drives one cycle of inputs right after a rising edge
    task automatic drive_instr(input logic valid, input simd_op_t op, input sew_t sew,
                               input src_sel_t src, input logic [63:0] rs1,
                               input logic [IMM_W-1:0] imm, input logic [VLEN-1:0] vs1,
                               input logic [VLEN-1:0] vs2, input logic [VLEN-1:0] old_vd,
                               input logic [VLEN/8-1:0] vm, input logic [TAG_W-1:0] tag);
        valid_i    <= valid;
        op_i       <= op;
        sew_i      <= sew;
        src_sel_i  <= src;
        rs1_data_i <= rs1;
        imm_i      <= imm;
        vs1_data_i <= vs1;
        vs2_data_i <= vs2;
        old_vd_i   <= old_vd;
        vm_i       <= vm;
        tag_i      <= tag;
        stim_count++;
        @(posedge clk_i);
    endtask

    // Wrap-around and VCNT corner cases at every element width
    task automatic run_directed();
        int              ew;
        logic [63:0]     r;
        logic [VLEN-1:0] ones;
        for (int s = 0; s < NUM_SEW; s++) begin
            ew   = 8 << s;
            r    = rand64() & width_mask(ew);
            ones = '1;
            drive_instr(1'b1, VADD, sew_t'(s), SRC_VV, rand64(), '0, rep_elem(64'd1, ew),
                        ones, rand_vec(), '1, TAG_W'(s));
            drive_instr(1'b1, VADD, sew_t'(s), SRC_VV, rand64(), '0, rep_elem(64'd1, ew),
                        rep_elem(width_mask(ew) >> 1, ew), rand_vec(), '1, TAG_W'(s + 4));
            drive_instr(1'b1, VSUB, sew_t'(s), SRC_VV, rand64(), '0, rep_elem(64'd1, ew),
                        '0, rand_vec(), '1, TAG_W'(s + 8));
            drive_instr(1'b1, VCNT, sew_t'(s), SRC_VV, r, '0, rand_vec(),
                        rep_elem(r, ew), rand_vec(), '1, TAG_W'(s + 12));
            drive_instr(1'b1, VCNT, sew_t'(s), SRC_VX, r, '0, rand_vec(),
                        elem_put(rep_elem(r, ew), 0, ew, ~r), rand_vec(), '1, TAG_W'(s + 16));
        end
    endtask

    task automatic run_random();
        simd_op_t        op;
        sew_t            sew;
        int              ew;
        int              ne;
        int              plen;
        logic [63:0]     rs1;
        logic [VLEN-1:0] vs2;
        op  = simd_op_t'($urandom % 9);
        sew = sew_t'($urandom % 4);
        ew  = 8 << int'(sew);
        ne  = VLEN / ew;
        rs1 = rand64();
        vs2 = rand_vec();
        if (op == VEXT && ($urandom % 4) != 0) begin
            rs1 = 64'($urandom % (2 * ne));  // Half of these are out of range
        end
        if (op == VCNT) begin
            plen = int'($urandom % (ne + 1));
            for (int e = 0; e < plen; e++) begin
                vs2 = elem_put(vs2, e, ew, rs1);
            end
            if (plen < ne) begin
                vs2 = elem_put(vs2, plen, ew, ~rs1);
            end
        end
        drive_instr(($urandom % 10) < 8, op, sew, src_sel_t'($urandom % 3), rs1,
                    IMM_W'($urandom), rand_vec(), vs2, rand_vec(), rand_mask(),
                    TAG_W'($urandom));
    endtask

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Inputs and outputs are both stable at the falling edge
    always @(negedge clk_i) begin
        expect_t entry;
        if (cycle > 0) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                entry = exp_q.pop_front();
                check_value("vd_valid_o", VLEN'(!entry.scalar), VLEN'(vd_valid_o));
                check_value("rd_valid_o", VLEN'(entry.scalar), VLEN'(rd_valid_o));
                check_value("tag_o", VLEN'(entry.tag), VLEN'(tag_o));
                if (entry.scalar) begin
                    check_value("rd_data_o", VLEN'(entry.rd), VLEN'(rd_data_o));
                end else begin
                    check_value("vd_data_o", entry.vd, vd_data_o);
                end
            end else begin
                check_value("vd_valid_o", '0, VLEN'(vd_valid_o));
                check_value("rd_valid_o", '0, VLEN'(rd_valid_o));
            end
        end
        if (rst_n_i && valid_i) begin
            entry.due    = cycle + 2;  // Sampled at the next edge, out one edge after that
            entry.scalar = (op_i == VMV_X_S) || (op_i == VEXT) || (op_i == VCNT);
            entry.vd     = expect_vd(op_i, sew_i, src_sel_i, rs1_data_i, imm_i, vs1_data_i,
                                     vs2_data_i, old_vd_i, vm_i);
            entry.rd     = expect_rd(op_i, sew_i, rs1_data_i, vs2_data_i);
            entry.tag    = tag_i;
            exp_q.push_back(entry);
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        op_i       = VADD;
        sew_i      = SEW_8;
        src_sel_i  = SRC_VV;
        rs1_data_i = '0;
        imm_i      = '0;
        vs1_data_i = '0;
        vs2_data_i = '0;
        old_vd_i   = '0;
        vm_i       = '0;
        tag_i      = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        run_directed();
        while (stim_count < NUM_CYCLES) begin
            run_random();
        end
        valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);  // Idle outputs checked once more
        @(negedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: simd_unit/simd_unit.sv
/*
 * SIMD execution unit
 * Two-stage vector pipeline: operand split, 64-bit lane array, result merge
 */
module simd_unit import simd_pkg::*; #(
    parameter int VLEN = 256  // Multiple of DATA_SIZE
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  simd_op_t             op_i,
    input  sew_t                 sew_i,
    input  src_sel_t             src_sel_i,
    input  logic [DATA_SIZE-1:0] rs1_data_i,
    input  logic [IMM_W-1:0]     imm_i,
    input  logic [VLEN-1:0]      vs1_data_i,
    input  logic [VLEN-1:0]      vs2_data_i,
    input  logic [VLEN-1:0]      old_vd_i,
    input  logic [VLEN/8-1:0]    vm_i,
    input  logic [TAG_W-1:0]     tag_i,
    output logic                 vd_valid_o,
    output logic [VLEN-1:0]      vd_data_o,
    output logic                 rd_valid_o,
    output logic [DATA_SIZE-1:0] rd_data_o,
    output logic [TAG_W-1:0]     tag_o
);

    localparam int NUM_LANES = VLEN / DATA_SIZE;

    // Stage 1 registers
    logic                 valid_q;
    simd_op_t             op_q;
    sew_t                 sew_q;
    logic [DATA_SIZE-1:0] rs1_q;
    logic [VLEN-1:0]      vs1_q;
    logic [VLEN-1:0]      vs2_q;
    logic [VLEN-1:0]      old_vd_q;
    logic [VLEN/8-1:0]    vm_q;
    logic [TAG_W-1:0]     tag_q;
    logic [VLEN-1:0]      lane_res;  // Concatenated lane outputs

    operand_split #(
        .VLEN (VLEN)
    ) operand_split_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .src_sel_i  (src_sel_i),
        .rs1_data_i (rs1_data_i),
        .imm_i      (imm_i),
        .vs1_data_i (vs1_data_i),
        .vs2_data_i (vs2_data_i),
        .old_vd_i   (old_vd_i),
        .vm_i       (vm_i),
        .tag_i      (tag_i),
        .valid_o    (valid_q),
        .op_o       (op_q),
        .sew_o      (sew_q),
        .rs1_o      (rs1_q),
        .vs1_o      (vs1_q),
        .vs2_o      (vs2_q),
        .old_vd_o   (old_vd_q),
        .vm_o       (vm_q),
        .tag_o      (tag_q)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        functional_unit functional_unit_inst (
            .op_i  (op_q),
            .sew_i (sew_q),
            .vs1_i (vs1_q[l*DATA_SIZE +: DATA_SIZE]),
            .vs2_i (vs2_q[l*DATA_SIZE +: DATA_SIZE]),
            .vd_o  (lane_res[l*DATA_SIZE +: DATA_SIZE])
        );
    end

    result_merge #(
        .VLEN (VLEN)
    ) result_merge_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_q),
        .op_i       (op_q),
        .sew_i      (sew_q),
        .rs1_i      (rs1_q),
        .vs2_i      (vs2_q),
        .lane_res_i (lane_res),
        .old_vd_i   (old_vd_q),
        .vm_i       (vm_q),
        .tag_i      (tag_q),
        .vd_valid_o (vd_valid_o),
        .vd_data_o  (vd_data_o),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .tag_o      (tag_o)
    );

endmodule

// File: simd_unit/result_merge.sv
/*
 * Result merge stage
 * Masks lane results over old vd, builds the scalar results and registers the outputs
 */
module result_merge import simd_pkg::*; #(
    parameter int VLEN = 256
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  simd_op_t             op_i,
    input  sew_t                 sew_i,
    input  logic [DATA_SIZE-1:0] rs1_i,
    input  logic [VLEN-1:0]      vs2_i,
    input  logic [VLEN-1:0]      lane_res_i,
    input  logic [VLEN-1:0]      old_vd_i,
    input  logic [VLEN/8-1:0]    vm_i,
    input  logic [TAG_W-1:0]     tag_i,
    output logic                 vd_valid_o,
    output logic [VLEN-1:0]      vd_data_o,
    output logic                 rd_valid_o,
    output logic [DATA_SIZE-1:0] rd_data_o,
    output logic [TAG_W-1:0]     tag_o
);

    logic [VLEN-1:0]      masked_res [NUM_SEW];
    logic [DATA_SIZE-1:0] elem0_res  [NUM_SEW];
    logic [DATA_SIZE-1:0] ext_res    [NUM_SEW];
    logic [DATA_SIZE-1:0] cnt_res    [NUM_SEW];
    logic [DATA_SIZE-1:0] rd_next;
    logic                 scalar_op;

    for (genvar w = 0; w < NUM_SEW; w++) begin : g_sew
        localparam int EW = 8 << w;
        localparam int NE = VLEN / EW;                   // Elements per register
        localparam int IW = (NE > 1) ? $clog2(NE) : 1;

        logic [EW-1:0]        elems [NE];
        logic [VLEN-1:0]      mask_w;
        logic [DATA_SIZE-1:0] ext_w;
        logic [DATA_SIZE-1:0] cnt_w;
        logic                 run;

        always_comb begin
            for (int e = 0; e < NE; e++) begin
                elems[e] = vs2_i[e*EW +: EW];
                // Mask bit of the lowest byte governs the whole element
                mask_w[e*EW +: EW] = vm_i[e*EW/8] ? lane_res_i[e*EW +: EW]
                                                  : old_vd_i[e*EW +: EW];
            end
        end

        // Index past the last element reads as zero
        always_comb begin
            ext_w = '0;
            if (rs1_i < DATA_SIZE'(NE)) begin
                ext_w = DATA_SIZE'(elems[rs1_i[IW-1:0]]);
            end
        end

        // Length of the run of equal elements from element 0
        always_comb begin
            cnt_w = '0;
            run   = 1'b1;
            for (int e = 0; e < NE; e++) begin
                run = run & lane_res_i[e*EW];
                if (run) begin
                    cnt_w = DATA_SIZE'(e + 1);
                end
            end
        end

        assign masked_res[w] = mask_w;
        assign elem0_res[w]  = DATA_SIZE'(elems[0]);  // Zero-extended
        assign ext_res[w]    = ext_w;
        assign cnt_res[w]    = cnt_w;
    end

    assign scalar_op = is_scalar_op(op_i);

    always_comb begin
        case (op_i)
            VMV_X_S: rd_next = elem0_res[sew_i];
            VEXT:    rd_next = ext_res[sew_i];
            VCNT:    rd_next = cnt_res[sew_i];
            default: rd_next = '0;
        endcase
    end

    // Only one valid per instruction, chosen by the operation class
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vd_valid_o <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            vd_valid_o <= valid_i & ~scalar_op;
            rd_valid_o <= valid_i & scalar_op;
        end
    end

    always_ff @(posedge clk_i) begin
        vd_data_o <= masked_res[sew_i];
        rd_data_o <= rd_next;
        tag_o     <= tag_i;
    end

endmodule

// File: simd_unit/functional_unit.sv
/*
 * SIMD lane functional unit
 * Element-wise arithmetic, logic and compare on one 64-bit lane at the current SEW
 */
module functional_unit import simd_pkg::*; (
    input  simd_op_t             op_i,
    input  sew_t                 sew_i,
    input  logic [DATA_SIZE-1:0] vs1_i,
    input  logic [DATA_SIZE-1:0] vs2_i,
    output logic [DATA_SIZE-1:0] vd_o
);

    // Results for every element width, picked by sew_i below
    logic [DATA_SIZE-1:0] add_res [NUM_SEW];
    logic [DATA_SIZE-1:0] sub_res [NUM_SEW];
    logic [DATA_SIZE-1:0] seq_res [NUM_SEW];

    for (genvar w = 0; w < NUM_SEW; w++) begin : g_sew
        localparam int EW = 8 << w;
        localparam int NE = DATA_SIZE / EW;

        logic [DATA_SIZE-1:0] add_w;
        logic [DATA_SIZE-1:0] sub_w;
        logic [DATA_SIZE-1:0] seq_w;

        // Each element is computed on its own, so carries stop at the boundary
        always_comb begin
            for (int e = 0; e < NE; e++) begin
                add_w[e*EW +: EW] = vs2_i[e*EW +: EW] + vs1_i[e*EW +: EW];
                sub_w[e*EW +: EW] = vs2_i[e*EW +: EW] - vs1_i[e*EW +: EW];
                seq_w[e*EW +: EW] = EW'(vs2_i[e*EW +: EW] == vs1_i[e*EW +: EW]);
            end
        end

        assign add_res[w] = add_w;
        assign sub_res[w] = sub_w;
        assign seq_res[w] = seq_w;
    end

    always_comb begin
        case (op_i)
            VADD:       vd_o = add_res[sew_i];
            VSUB:       vd_o = sub_res[sew_i];
            VAND:       vd_o = vs2_i & vs1_i;  // Bitwise, width independent
            VOR:        vd_o = vs2_i | vs1_i;
            VXOR:       vd_o = vs2_i ^ vs1_i;
            VSEQ, VCNT: vd_o = seq_res[sew_i];  // VCNT counts these in the merger
            default:    vd_o = '0;
        endcase
    end

endmodule

// File: simd_unit/operand_split.sv
/*
 * Operand split stage
 * Picks the vs1 source, replicates rs1 or imm per SEW and registers operands for the lanes
 */
module operand_split import simd_pkg::*; #(
    parameter int VLEN = 256
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  simd_op_t             op_i,
    input  sew_t                 sew_i,
    input  src_sel_t             src_sel_i,
    input  logic [DATA_SIZE-1:0] rs1_data_i,
    input  logic [IMM_W-1:0]     imm_i,
    input  logic [VLEN-1:0]      vs1_data_i,
    input  logic [VLEN-1:0]      vs2_data_i,
    input  logic [VLEN-1:0]      old_vd_i,
    input  logic [VLEN/8-1:0]    vm_i,
    input  logic [TAG_W-1:0]     tag_i,
    output logic                 valid_o,
    output simd_op_t             op_o,
    output sew_t                 sew_o,
    output logic [DATA_SIZE-1:0] rs1_o,
    output logic [VLEN-1:0]      vs1_o,
    output logic [VLEN-1:0]      vs2_o,
    output logic [VLEN-1:0]      old_vd_o,
    output logic [VLEN/8-1:0]    vm_o,
    output logic [TAG_W-1:0]     tag_o
);

    localparam int NUM_LANES = VLEN / DATA_SIZE;

    logic                 use_scalar;
    logic                 use_imm;
    logic [DATA_SIZE-1:0] scalar_val;
    logic [DATA_SIZE-1:0] lane_pattern;
    logic [VLEN-1:0]      vs1_sel;

    // VCNT always compares against rs1, whatever the source field says
    assign use_scalar = (src_sel_i == SRC_VX) || (src_sel_i == SRC_VI) || (op_i == VCNT);
    assign use_imm    = (src_sel_i == SRC_VI) && (op_i != VCNT);

    assign scalar_val = use_imm ? {{(DATA_SIZE-IMM_W){imm_i[IMM_W-1]}}, imm_i}
                                : rs1_data_i;

    // Sign extension to 64 bits, truncated by SEW, is the SEW-wide sign extension
    assign lane_pattern = replicate_sew(scalar_val, sew_i);
    assign vs1_sel      = use_scalar ? {NUM_LANES{lane_pattern}} : vs1_data_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Operands and control fields for the lane array
    always_ff @(posedge clk_i) begin
        op_o     <= op_i;
        sew_o    <= sew_i;
        rs1_o    <= rs1_data_i;  // VEXT index
        vs1_o    <= vs1_sel;
        vs2_o    <= vs2_data_i;
        old_vd_o <= old_vd_i;
        vm_o     <= vm_i;
        tag_o    <= tag_i;
    end

endmodule

// File: common/simd_pkg.sv
/*
 * SIMD execution stage definitions
 * Operation, element width and operand source encodings for the vector datapath
 */
package simd_pkg;

    localparam int DATA_SIZE = 64;  // Lane width
    localparam int TAG_W     = 5;   // Destination register tag
    localparam int IMM_W     = 5;
    localparam int NUM_SEW   = 4;   // Number of supported element widths

    // Element width, log2 of the element size in bytes
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    typedef enum logic [1:0] {
        SRC_VV = 2'b00,  // vs1 register
        SRC_VX = 2'b01,  // Scalar rs1
        SRC_VI = 2'b10   // Sign-extended immediate
    } src_sel_t;

    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,  // vs2 - vs1
        VAND    = 4'd2,
        VOR     = 4'd3,
        VXOR    = 4'd4,
        VSEQ    = 4'd5,
        VMV_X_S = 4'd6,  // Element 0 to rd
        VEXT    = 4'd7,  // Element rs1 to rd
        VCNT    = 4'd8   // Leading equal count to rd
    } simd_op_t;

    // Operations that write the scalar destination
    function automatic logic is_scalar_op(simd_op_t op);
        return (op == VMV_X_S) || (op == VEXT) || (op == VCNT);
    endfunction

    // Copy the low SEW bits of a scalar over a whole lane
    function automatic logic [DATA_SIZE-1:0] replicate_sew(logic [DATA_SIZE-1:0] val,
                                                           sew_t sew);
        logic [DATA_SIZE-1:0] pattern;
        case (sew)
            SEW_8:   pattern = {8{val[7:0]}};
            SEW_16:  pattern = {4{val[15:0]}};
            SEW_32:  pattern = {2{val[31:0]}};
            default: pattern = val;
        endcase
        return pattern;
    endfunction

endpackage
